/* filelist.f */
logic/wiscPkg.sv
logic/controlUnit.sv
logic/aluCore.sv
logic/regFile.sv
logic/programCounter.sv
logic/cpuSequencer.sv
logic/wiscCore.sv
testbench/wiscCore_chk.sv
testbench/wiscCoreTb.sv

/* Bender.yml */
package:
  name: wisc_core

sources:
  - logic/wiscPkg.sv
  - logic/controlUnit.sv
  - logic/aluCore.sv
  - logic/regFile.sv
  - logic/programCounter.sv
  - logic/cpuSequencer.sv
  - logic/wiscCore.sv
  - target: simulation
    files:
      - testbench/wiscCore_chk.sv
      - testbench/wiscCoreTb.sv

/* testbench/wiscCoreTb.sv */
// directed tests for the core; word addressed memory model covers 2 KiB, code at ResetVec, data below it
`timescale 1ns/10ps
module wiscCoreTb;
   import wiscPkg::*;

   localparam wordT ResetVec      = 16'h0100;   // code base
   localparam wordT DataBase      = 16'h0040;   // store area reachable by LBI
   localparam int   MemWords      = 1024;
   localparam int   NumRuns       = 7;          // programs run below
   localparam int   MaxFetches    = 16;         // longest program plus slack
   localparam int   WorstInstr    = 14;         // fetch and mem with 3 waits each plus 4 single cycles
   localparam int   RunCycles     = 10 + 20 + MaxFetches * WorstInstr;
   localparam int   TimeoutCycles = NumRuns * RunCycles + 200;

   logic clk;
   logic rstN;
   logic wbCyc;
   logic wbStb;
   logic wbWe;
   wordT wbAdr;
   wordT wbDatW;
   wordT wbDatR;
   logic wbAck;
   logic halted;
   logic err;

   wordT        mem [MemWords];
   wordT        codeQ[$];       // program image
   wordT        wrAdrLog[$];
   wordT        wrDatLog[$];
   wordT        readLog[$];     // read addresses including fetches
   wordT        expAdr[$];
   wordT        expDat[$];
   wordT        expPc[$];
   logic [1:0]  waitLeft;
   logic        randWaits;
   logic [31:0] lfsrState;
   int          errorCount;
   int          errorsBefore;
   int          testCount;
   int          failCount;
   int          cycleCount;

   wiscCore #(.ResetVector(ResetVec)) uut (
      .clk, .rstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW,
      .wbDatR, .wbAck, .halted, .err
   );

   bind wiscCore wiscCore_chk uChk (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;                      // 100 ns period
   end

   // one step of a right shifting Galois LFSR per bit
   function automatic logic lfsrBit();
      logic b;
      b = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (b) lfsrState = lfsrState ^ 32'h8020_0003;
      return b;
   endfunction

   function automatic logic [1:0] drawWaits();
      logic [1:0] w;
      w[0] = lfsrBit();
      w[1] = lfsrBit();
      return w;
   endfunction

   function automatic wordT sext5(logic [4:0] v);
      return {{11{v[4]}}, v};
   endfunction

   function automatic wordT sext8(logic [7:0] v);
      return {{8{v[7]}}, v};
   endfunction

   function automatic wordT encImm5(opcodeT op, logic [2:0] rs, logic [2:0] rd, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic wordT encImm8(opcodeT op, logic [2:0] rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic wordT encReg(logic [2:0] rs, logic [2:0] rt, logic [2:0] rd,
                                   logic [1:0] func);
      return {OpAlu, rs, rt, rd, func};
   endfunction

   function automatic wordT jumpTarget(wordT pc, wordT disp);
      return pc + 16'd2 + disp;                    // relative to the next instruction
   endfunction

   // Wishbone slave acking after the drawn number of wait states
   always @(posedge clk) begin
      if (!rstN) begin
         wbAck    <= 1'b0;
         waitLeft <= randWaits ? drawWaits() : 2'd0;
      end else if (wbAck) begin
         wbAck <= 1'b0;                            // master drops cyc on this edge
      end else if (wbCyc && wbStb) begin
         if (waitLeft != 2'd0) begin
            waitLeft <= waitLeft - 2'd1;
         end else begin
            wbAck    <= 1'b1;
            waitLeft <= randWaits ? drawWaits() : 2'd0;
            if (wbAdr[0]) begin
               $display("Unaligned bus address %h", wbAdr);
               errorCount++;
            end
            if (wbWe) begin
               mem[wbAdr[10:1]] = wbDatW;
               wrAdrLog.push_back(wbAdr);
               wrDatLog.push_back(wbDatW);
            end else begin
               wbDatR <= mem[wbAdr[10:1]];
               readLog.push_back(wbAdr);
            end
         end
      end
   end

   initial begin
      cycleCount = 0;
      while (cycleCount < TimeoutCycles) begin
         @(posedge clk);
         cycleCount++;
      end
      $display("Timeout after %0d cycles, the core never finished", TimeoutCycles);
      $display("Errors found");
      $finish;
   end

   task automatic checkWord(input string name, input wordT got, input wordT exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         errorCount++;
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h expected %h", name, got, exp);
         errorCount++;
      end
   endtask

   task automatic startTest();
      errorsBefore = errorCount;
      codeQ  = {};
      expAdr = {};
      expDat = {};
      expPc  = {};
   endtask

   task automatic finishTest(input string name);
      testCount++;
      if (errorCount == errorsBefore) begin
         $display("test %-14s ok", name);
      end else begin
         failCount++;
         $display("test %-14s FAILED", name);
      end
   endtask

   // load image under reset, release and wait for STOP
   task automatic runProgram(input logic randomWait);
      @(posedge clk);
      rstN      <= 1'b0;
      randWaits = randomWait;
      for (int i = 0; i < MemWords; i++) begin
         mem[i] = wordT'(i) ^ 16'hC3A5;            // fill tied to the address
      end
      for (int i = 0; i < codeQ.size(); i++) begin
         mem[int'(ResetVec[10:1]) + i] = codeQ[i];
      end
      wrAdrLog = {};
      wrDatLog = {};
      readLog  = {};
      repeat (8) @(posedge clk);
      rstN <= 1'b1;
      while (!halted) begin
         @(posedge clk);
      end
   endtask

   task automatic compareWrites();
      if (wrAdrLog.size() != expAdr.size()) begin
         $display("Wrong number of bus writes, got %0d and expected %0d",
                  wrAdrLog.size(), expAdr.size());
         errorCount++;
      end else begin
         for (int k = 0; k < expAdr.size(); k++) begin
            checkWord("wbAdr", wrAdrLog[k], expAdr[k]);
            checkWord("wbDatW", wrDatLog[k], expDat[k]);
         end
      end
   endtask

   task automatic compareFetches();
      if (readLog.size() != expPc.size()) begin
         $display("Wrong number of fetches, got %0d and expected %0d",
                  readLog.size(), expPc.size());
         errorCount++;
      end else begin
         for (int k = 0; k < expPc.size(); k++) begin
            checkWord("wbAdr", readLog[k], expPc[k]);
         end
      end
   endtask

   task automatic immTest(input string name, input logic randomWait);
      wordT r1;
      startTest();
      r1 = sext8(8'hA5);
      codeQ.push_back(encImm8(OpLbi, 3'd1, 8'hA5));
      codeQ.push_back(encImm8(OpLbi, 3'd7, DataBase[7:0]));
      codeQ.push_back(encImm5(OpAddi, 3'd1, 3'd2, 5'h0B));
      codeQ.push_back(encImm5(OpSubi, 3'd1, 3'd3, 5'h13));
      codeQ.push_back(encImm5(OpXori, 3'd1, 3'd4, 5'h1F));
      codeQ.push_back(encImm5(OpAndni, 3'd1, 3'd5, 5'h07));
      for (int r = 1; r <= 5; r++) begin
         codeQ.push_back(encImm5(OpSt, 3'd7, 3'(r), 5'(2 * (r - 1))));
         expAdr.push_back(DataBase + wordT'(2 * (r - 1)));
      end
      codeQ.push_back({OpHalt, 11'b0});
      expDat.push_back(r1);
      expDat.push_back(r1 + sext5(5'h0B));
      expDat.push_back(sext5(5'h13) - r1);         // imm minus rs
      expDat.push_back(r1 ^ {11'b0, 5'h1F});       // logic imms zero extend
      expDat.push_back(r1 & ~{11'b0, 5'h07});
      runProgram(randomWait);
      checkFlag("err", err, 1'b0);
      compareWrites();
      finishTest(name);
   endtask

   task automatic regTest();
      wordT a;
      wordT b;
      startTest();
      a = sext8(8'h3C);
      b = sext8(8'hF1);
      codeQ.push_back(encImm8(OpLbi, 3'd1, 8'h3C));
      codeQ.push_back(encImm8(OpLbi, 3'd2, 8'hF1));
      codeQ.push_back(encImm8(OpLbi, 3'd7, DataBase[7:0]));
      for (int f = 0; f < 4; f++) begin
         codeQ.push_back(encReg(3'd1, 3'd2, 3'(3 + f), 2'(f)));
      end
      for (int r = 3; r <= 6; r++) begin
         codeQ.push_back(encImm5(OpSt, 3'd7, 3'(r), 5'(2 * (r - 3))));
         expAdr.push_back(DataBase + wordT'(2 * (r - 3)));
      end
      codeQ.push_back({OpHalt, 11'b0});
      expDat.push_back(a + b);
      expDat.push_back(b - a);                     // rt minus rs
      expDat.push_back(a ^ b);
      expDat.push_back(a & ~b);
      runProgram(1'b0);
      checkFlag("err", err, 1'b0);
      compareWrites();
      finishTest("register alu");
   endtask

   task automatic loadStoreTest();
      startTest();
      codeQ.push_back(encImm8(OpLbi, 3'd1, 8'h9C));
      codeQ.push_back(encImm8(OpLbi, 3'd7, DataBase[7:0]));
      codeQ.push_back(encImm5(OpSt, 3'd7, 3'd1, 5'd4));
      codeQ.push_back(encImm5(OpLd, 3'd7, 3'd2, 5'd4));   // read back the word just stored
      codeQ.push_back(encImm5(OpSt, 3'd7, 3'd2, 5'd10));
      codeQ.push_back({OpHalt, 11'b0});
      expAdr.push_back(DataBase + 16'd4);
      expDat.push_back(sext8(8'h9C));
      expAdr.push_back(DataBase + 16'd10);
      expDat.push_back(sext8(8'h9C));
      runProgram(1'b0);
      checkFlag("err", err, 1'b0);
      compareWrites();
      finishTest("load store");
   endtask

   task automatic branchTest();
      wordT b;
      startTest();
      b = ResetVec;
      codeQ.push_back(encImm8(OpLbi, 3'd1, 8'd0));     // r1 zero
      codeQ.push_back(encImm8(OpLbi, 3'd2, 8'd3));     // r2 nonzero
      codeQ.push_back(encImm8(OpBeqz, 3'd1, 8'd2));    // b+4 taken
      codeQ.push_back({OpHalt, 11'b0});
      codeQ.push_back(encImm8(OpBnez, 3'd1, 8'd4));    // b+8 falls through
      codeQ.push_back(encImm8(OpBeqz, 3'd2, 8'd4));    // b+A falls through
      codeQ.push_back(encImm8(OpBnez, 3'd2, 8'd2));    // b+C taken
      codeQ.push_back({OpHalt, 11'b0});
      codeQ.push_back(encImm8(OpJ, 3'd0, 8'd4));       // b+10 with imm11 of 4
      codeQ.push_back({OpHalt, 11'b0});
      codeQ.push_back({OpHalt, 11'b0});
      codeQ.push_back({OpJ, 11'd2});                   // b+16
      codeQ.push_back({OpHalt, 11'b0});                // b+18 end
      codeQ.push_back({OpJ, 11'h7FC});                 // b+1A jumps back
      expPc.push_back(b);
      expPc.push_back(b + 16'h2);
      expPc.push_back(b + 16'h4);
      expPc.push_back(jumpTarget(b + 16'h4, sext8(8'd2)));
      expPc.push_back(b + 16'hA);
      expPc.push_back(b + 16'hC);
      expPc.push_back(jumpTarget(b + 16'hC, sext8(8'd2)));
      expPc.push_back(jumpTarget(b + 16'h10, 16'd4));
      expPc.push_back(jumpTarget(b + 16'h16, 16'd2));
      expPc.push_back(jumpTarget(b + 16'h1A, 16'hFFFC));
      runProgram(1'b0);
      checkFlag("err", err, 1'b0);
      compareFetches();
      finishTest("branches");
   endtask

   task automatic stopTest(input string name, input wordT stopInstr, input logic expErr);
      int busCycles;
      startTest();
      busCycles = 0;
      codeQ.push_back({OpNop, 11'b0});
      codeQ.push_back(stopInstr);
      runProgram(1'b0);
      checkFlag("err", err, expErr);
      repeat (20) begin
         @(posedge clk);
         if (wbCyc || wbStb) busCycles++;
      end
      if (busCycles != 0) begin
         $display("Bus active in %0d cycles after the core stopped", busCycles);
         errorCount++;
      end
      checkFlag("halted", halted, 1'b1);           // STOP holds
      finishTest(name);
   endtask

   initial begin
      rstN       = 1'b0;
      wbAck      = 1'b0;
      wbDatR     = '0;
      randWaits  = 1'b0;
      lfsrState  = 32'he24b;
      errorCount = 0;
      testCount  = 0;
      failCount  = 0;
      immTest("immediates", 1'b0);
      regTest();
      loadStoreTest();
      branchTest();
      immTest("random waits", 1'b1);
      stopTest("halt", {OpHalt, 11'b0}, 1'b0);
      stopTest("illegal", 16'h1000, 1'b1);         // siic opcode is not kept
      $display("tests %0d, failed %0d, errors %0d", testCount, failCount, errorCount);
      if (errorCount == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

/* testbench/wiscCore_chk.sv */
// bus and stop rules for the core, sampled on clk and idle while rstN is low
`timescale 1ns/10ps
module wiscCore_chk (
   input logic          clk,
   input logic          rstN,
   input logic          wbCyc,
   input logic          wbStb,
   input logic          wbWe,
   input wiscPkg::wordT wbAdr,
   input wiscPkg::wordT wbDatW,
   input logic          wbAck,
   input logic          halted,
   input logic          err
);

   aStbCyc: assert property (@(posedge clk) disable iff (!rstN) wbStb |-> wbCyc)
      else $error("wbStb high without wbCyc");

   // request held until the slave acks
   aStable: assert property (@(posedge clk) disable iff (!rstN)
      (wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbDatW) && $stable(wbWe)))
      else $error("bus request changed before wbAck");

   aQuietStop: assert property (@(posedge clk) disable iff (!rstN) halted |-> !wbCyc)
      else $error("bus cycle while halted");

   aErrStop: assert property (@(posedge clk) disable iff (!rstN) err |-> halted)
      else $error("err raised without halted");

endmodule

/* logic/wiscCore.sv */
// core top with one Wishbone classic master port for code and data; only word aligned accesses
`timescale 1ns/10ps
module wiscCore #(
   parameter wiscPkg::wordT ResetVector = 16'h0000
) (
   input  logic          clk,
   input  logic          rstN,
   output logic          wbCyc,
   output logic          wbStb,
   output logic          wbWe,
   output wiscPkg::wordT wbAdr,
   output wiscPkg::wordT wbDatW,
   input  wiscPkg::wordT wbDatR,
   input  logic          wbAck,
   output logic          halted,
   output logic          err
);
   import wiscPkg::*;

   wordT      instr;
   wordT      pc;
   wordT      pcOffset;
   wordT      rdA;
   wordT      rdB;
   wordT      opB;
   wordT      imm5Ext;
   wordT      imm8Ext;
   wordT      aluResult;
   wordT      memData;
   wordT      wrData;
   logic [2:0] wrAddr;
   logic      irLoad;
   logic      pcStep;
   logic      regWrEn;
   logic      regWrt;
   logic      memRd;
   logic      memWr;
   logic      haltReq;
   logic      illegal;
   logic      invA;
   logic      invB;
   logic      cin;
   logic      zeroExt;
   logic      aluZero;
   logic [1:0] logicOp;
   bSrcT      bSrc;
   wbSrcT     wbSrc;
   regDestT   regDest;
   brchCondT  brchCond;

   controlUnit uCtrl (
      .clk, .rstN, .irLoad,
      .instrIn(wbDatR),                    // fetch data straight off the bus
      .instr, .regWrt, .memRd, .memWr, .haltReq, .illegal,
      .invA, .invB, .cin, .zeroExt, .logicOp,
      .bSrc, .wbSrc, .regDest, .brchCond, .pcOffset
   );

   assign imm5Ext = zeroExt ? {11'b0, instr[4:0]} : {{11{instr[4]}}, instr[4:0]};
   assign imm8Ext = {{8{instr[7]}}, instr[7:0]};   // LBI value

   always_comb begin
      case (bSrc)
         BImm5:   opB = imm5Ext;
         BZero:   opB = '0;                // branch test on rs
         default: opB = rdB;
      endcase
   end

   aluCore uAlu (
      .opA(rdA), .opB, .invA, .invB, .cin, .logicOp,
      .result(aluResult), .zero(aluZero),
      .sign()                              // no signed branches kept
   );

   always_comb begin
      case (wbSrc)
         WbMem:   wrData = memData;
         WbImm8:  wrData = imm8Ext;
         default: wrData = aluResult;
      endcase
   end

   // LBI writes its rs field, everything else follows regDest
   assign wrAddr = (wbSrc == WbImm8) ? instr[10:8] :
                   (regDest == DestR) ? instr[4:2] : instr[7:5];

   regFile uRegs (
      .clk, .rstN, .wrEn(regWrEn),
      .rdAddrA(instr[10:8]), .rdAddrB(instr[7:5]), .wrAddr,
      .wrData, .rdA, .rdB
   );

   programCounter #(.ResetVector(ResetVector)) uPc (
      .clk, .rstN, .pcStep, .aluZero, .brchCond, .pcOffset, .pc
   );

   cpuSequencer uSeq (
      .clk, .rstN, .memRd, .memWr, .regWrt, .haltReq, .illegal,
      .wbAck, .wbDatR, .pc, .aluResult,
      .storeData(rdB),                     // ST data is the rd field at 7:5
      .irLoad, .pcStep, .regWrEn,
      .wbCyc, .wbStb, .wbWe, .halted, .err,
      .wbAdr, .wbDatW, .memData
   );

endmodule

/* logic/cpuSequencer.sv */
// multicycle FSM and Wishbone classic master; one bus cycle at a time and STOP is left only by reset
`timescale 1ns/10ps
module cpuSequencer (
   input  logic          clk,
   input  logic          rstN,
   input  logic          memRd,
   input  logic          memWr,
   input  logic          regWrt,
   input  logic          haltReq,
   input  logic          illegal,
   input  logic          wbAck,
   input  wiscPkg::wordT wbDatR,
   input  wiscPkg::wordT pc,
   input  wiscPkg::wordT aluResult,
   input  wiscPkg::wordT storeData,
   output logic          irLoad,
   output logic          pcStep,
   output logic          regWrEn,
   output logic          wbCyc,
   output logic          wbStb,
   output logic          wbWe,
   output logic          halted,
   output logic          err,
   output wiscPkg::wordT wbAdr,
   output wiscPkg::wordT wbDatW,
   output wiscPkg::wordT memData
);

   typedef enum logic [2:0] {
      Idle, Fetch, Decode, Exec, Mem, Wb, Stop
   } stateT;

   stateT state;
   stateT nextState;
   logic  busActive;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= Idle;
         err   <= 1'b0;
      end else begin
         state <= nextState;
         if (state == Decode && illegal) begin
            err <= 1'b1;                   // sticky until reset
         end
      end
   end

   always_comb begin
      nextState = state;
      case (state)
         Idle:   nextState = Fetch;        // one quiet cycle after reset
         Fetch:  if (wbAck) nextState = Decode;
         Decode: nextState = (haltReq || illegal) ? Stop : Exec;
         Exec: begin
            if (memRd || memWr) nextState = Mem;
            else if (regWrt)    nextState = Wb;
            else                nextState = Fetch;
         end
         Mem:    if (wbAck) nextState = regWrt ? Wb : Fetch;
         Wb:     nextState = Fetch;
         Stop:   nextState = Stop;
         default: nextState = Idle;
      endcase
   end

   // load data kept for the writeback cycle
   always_ff @(posedge clk) begin
      if (state == Mem && wbAck && memRd) begin
         memData <= wbDatR;
      end
   end

   assign busActive = (state == Fetch) || (state == Mem);
   assign wbCyc     = busActive;           // cyc and stb move together
   assign wbStb     = busActive;
   assign wbWe      = (state == Mem) && memWr;
   assign wbAdr     = (state == Mem) ? aluResult : pc;  // both steady for the whole cycle
   assign wbDatW    = storeData;

   assign irLoad  = (state == Fetch) && wbAck;
   assign pcStep  = (state == Exec);
   assign regWrEn = (state == Wb);
   assign halted  = (state == Stop);

endmodule

/* logic/programCounter.sv */
// program counter that advances only on pcStep; targets are relative to PC+2 and must stay aligned
`timescale 1ns/10ps
module programCounter #(
   parameter wiscPkg::wordT ResetVector = 16'h0000
) (
   input  logic              clk,
   input  logic              rstN,
   input  logic              pcStep,
   input  logic              aluZero,
   input  wiscPkg::brchCondT brchCond,
   input  wiscPkg::wordT     pcOffset,
   output wiscPkg::wordT     pc
);
   import wiscPkg::*;

   logic taken;
   wordT pcPlus2;

   assign pcPlus2 = pc + 16'd2;

   always_comb begin
      case (brchCond)
         BrZero:    taken = aluZero;       // BEQZ
         BrNotZero: taken = !aluZero;      // BNEZ
         BrAlways:  taken = 1'b1;          // J
         default:   taken = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= ResetVector;
      end else if (pcStep) begin
         pc <= taken ? pcPlus2 + pcOffset : pcPlus2;
      end
   end

endmodule

/* logic/regFile.sv */
// eight general registers, reads are combinational so a write shows on the next cycle
`timescale 1ns/10ps
module regFile (
   input  logic          clk,
   input  logic          rstN,
   input  logic          wrEn,
   input  logic [2:0]    rdAddrA,
   input  logic [2:0]    rdAddrB,
   input  logic [2:0]    wrAddr,
   input  wiscPkg::wordT wrData,
   output wiscPkg::wordT rdA,
   output wiscPkg::wordT rdB
);
   import wiscPkg::*;

   wordT regs [NumRegs];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0;                 // all registers start at zero
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;           // lands at end of WB
      end
   end

   assign rdA = regs[rdAddrA];             // rs field
   assign rdB = regs[rdAddrB];             // rt field or store data

endmodule

/* logic/aluCore.sv */
// combinational adder and logic unit; flags describe the result only and carry out is not kept
`timescale 1ns/10ps
module aluCore (
   input  wiscPkg::wordT opA,
   input  wiscPkg::wordT opB,
   input  logic          invA,
   input  logic          invB,
   input  logic          cin,
   input  logic [1:0]    logicOp,
   output wiscPkg::wordT result,
   output logic          zero,
   output logic          sign
);
   import wiscPkg::*;

   wordT a;
   wordT b;

   assign a = invA ? ~opA : opA;     // subtract uses ~a + b + 1
   assign b = invB ? ~opB : opB;     // andn path

   always_comb begin
      case (logicOp)
         AluAdd:  result = a + b + {15'b0, cin};
         AluXor:  result = a ^ b;
         AluAnd:  result = a & b;
         default: result = a;        // unused code passes a
      endcase
   end

   // with b forced to zero these test rs for branches
   assign zero = (result == '0);
   assign sign = result[15];

endmodule

/* logic/controlUnit.sv */
// instruction register and decoder; decoded fields follow the register one cycle after irLoad
`timescale 1ns/10ps
module controlUnit (
   input  logic               clk,
   input  logic               rstN,
   input  logic               irLoad,
   input  wiscPkg::wordT      instrIn,
   output wiscPkg::wordT      instr,
   output logic               regWrt,
   output logic               memRd,
   output logic               memWr,
   output logic               haltReq,
   output logic               illegal,
   output logic               invA,
   output logic               invB,
   output logic               cin,
   output logic               zeroExt,
   output logic [1:0]         logicOp,
   output wiscPkg::bSrcT      bSrc,
   output wiscPkg::wbSrcT     wbSrc,
   output wiscPkg::regDestT   regDest,
   output wiscPkg::brchCondT  brchCond,
   output wiscPkg::wordT      pcOffset
);
   import wiscPkg::*;

   opcodeT opcode;
   wordT   imm8Ext;
   wordT   imm11Ext;

   // instruction register, holds a NOP out of reset
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         instr <= {OpNop, 11'b0};
      end else if (irLoad) begin
         instr <= instrIn;                  // fetch data on ack
      end
   end

   assign opcode   = opcodeT'(instr[15:11]);
   assign imm8Ext  = {{8{instr[7]}}, instr[7:0]};     // branch displacement
   assign imm11Ext = {{5{instr[10]}}, instr[10:0]};   // jump displacement

   always_comb begin
      regWrt   = 1'b0;                      // defaults describe a NOP
      memRd    = 1'b0;
      memWr    = 1'b0;
      haltReq  = 1'b0;
      illegal  = 1'b0;
      invA     = 1'b0;
      invB     = 1'b0;
      cin      = 1'b0;
      zeroExt  = 1'b0;
      logicOp  = AluAdd;
      bSrc     = BRegB;
      wbSrc    = WbAlu;
      regDest  = DestI;
      brchCond = BrNone;
      pcOffset = imm8Ext;
      case (opcode)
         OpHalt: begin
            haltReq = 1'b1;
         end
         OpNop: begin
         end
         OpAddi: begin
            regWrt = 1'b1;
            bSrc   = BImm5;                 // rs + sext imm5
         end
         OpSubi: begin
            regWrt = 1'b1;
            bSrc   = BImm5;
            invA   = 1'b1;                  // imm5 - rs
            cin    = 1'b1;
         end
         OpXori: begin
            regWrt  = 1'b1;
            bSrc    = BImm5;
            zeroExt = 1'b1;
            logicOp = AluXor;
         end
         OpAndni: begin
            regWrt  = 1'b1;
            bSrc    = BImm5;
            zeroExt = 1'b1;
            invB    = 1'b1;                 // rs and not imm5
            logicOp = AluAnd;
         end
         OpSt: begin
            memWr = 1'b1;
            bSrc  = BImm5;                  // address rs + sext imm5
         end
         OpLd: begin
            memRd  = 1'b1;
            regWrt = 1'b1;
            bSrc   = BImm5;
            wbSrc  = WbMem;
         end
         OpLbi: begin
            regWrt = 1'b1;
            wbSrc  = WbImm8;                // dest is the rs field
         end
         OpAlu: begin
            regWrt  = 1'b1;
            regDest = DestR;
            case (instr[1:0])
               2'b01: begin                 // SUB rt - rs
                  invA = 1'b1;
                  cin  = 1'b1;
               end
               2'b10: logicOp = AluXor;
               2'b11: begin                 // ANDN rs and not rt
                  invB    = 1'b1;
                  logicOp = AluAnd;
               end
               default: ;                   // ADD
            endcase
         end
         OpBeqz: begin
            bSrc     = BZero;               // alu passes rs
            brchCond = BrZero;
         end
         OpBnez: begin
            bSrc     = BZero;
            brchCond = BrNotZero;
         end
         OpJ: begin
            brchCond = BrAlways;
            pcOffset = imm11Ext;
         end
         default: begin
            illegal = 1'b1;                 // anything outside the subset
         end
      endcase
   end

endmodule

/* logic/wiscPkg.sv */
// shared types for the WISC-SP22 subset core; the logicOp codes are the ALU function select
package wiscPkg;

   typedef logic [15:0] wordT;             // data, address and instruction word

   localparam int NumRegs = 8;             // architectural register count

   // major opcodes kept in this core, ISA encodings
   typedef enum logic [4:0] {
      OpHalt  = 5'b0_0000,
      OpNop   = 5'b0_0001,
      OpJ     = 5'b0_0100,
      OpAddi  = 5'b0_1000,
      OpSubi  = 5'b0_1001,
      OpXori  = 5'b0_1010,
      OpAndni = 5'b0_1011,
      OpBeqz  = 5'b0_1100,
      OpBnez  = 5'b0_1101,
      OpSt    = 5'b1_0000,
      OpLd    = 5'b1_0001,
      OpLbi   = 5'b1_1000,
      OpAlu   = 5'b1_1011            // ADD SUB XOR ANDN by func bits
   } opcodeT;

   typedef enum logic [1:0] {
      WbAlu  = 2'd0,                  // alu result
      WbMem  = 2'd1,                  // load data
      WbImm8 = 2'd2                   // sign extended imm8 for LBI
   } wbSrcT;

   typedef enum logic [1:0] {
      BRegB = 2'd0,                   // register read port B
      BImm5 = 2'd1,                   // extended imm5
      BZero = 2'd2                    // zero for branch tests
   } bSrcT;

   typedef enum logic {
      DestI = 1'b0,                   // instr bits 7:5
      DestR = 1'b1                    // instr bits 4:2
   } regDestT;

   typedef enum logic [1:0] {
      BrNone    = 2'd0,
      BrZero    = 2'd1,
      BrNotZero = 2'd2,
      BrAlways  = 2'd3
   } brchCondT;

   // alu function select
   localparam logic [1:0] AluAdd = 2'b00;  // a + b + cin
   localparam logic [1:0] AluXor = 2'b01;
   localparam logic [1:0] AluAnd = 2'b10;

endpackage
